//--- hdl/nice_pkg.sv
package nice_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // data path
   ////////////////////////////////////////////////////////////////////////////

   // data and address width
   localparam int XLEN = 32;

   // one data or address word
   typedef logic [XLEN-1:0] word_t;

   ////////////////////////////////////////////////////////////////////////////
   // row buffer
   ////////////////////////////////////////////////////////////////////////////

   // entries in the row buffer
   localparam int ROWBUF_DP = 4;
   localparam int ROWBUF_IDX_W = 2;

   typedef logic [ROWBUF_IDX_W-1:0] rowbuf_idx_t;

   // words moved by one instruction
   localparam int COL_NUM = 3;

   // byte step between words
   localparam int WORD_BYTES = 4;

   ////////////////////////////////////////////////////////////////////////////
   // instruction encoding
   ////////////////////////////////////////////////////////////////////////////

   // custom-3, R type
   localparam logic [6:0] OPCODE_CUSTOM3 = 7'h7b;

   // func3 per instruction
   localparam logic [2:0] F3_LBUF   = 3'd2;
   localparam logic [2:0] F3_SBUF   = 3'd2;
   localparam logic [2:0] F3_ROWSUM = 3'd6;

   // func7 per instruction
   localparam logic [6:0] F7_LBUF   = 7'd1;
   localparam logic [6:0] F7_SBUF   = 7'd2;
   localparam logic [6:0] F7_ROWSUM = 7'd6;

   // memory command size code for a full word
   localparam logic [1:0] ICB_SIZE_WORD = 2'd2;

   // operation held for the busy period
   typedef enum logic [1:0] {
      op_lbuf,
      op_sbuf,
      op_rowsum
   } nice_op_t;

endpackage

//--- hdl/nice_req_decode.sv
`timescale 1ns/1ps

module nice_req_decode (
   input  logic               nice_clk,
   input  logic               rst,
   // request from the core
   input  logic               req_valid,
   output logic               req_ready,
   input  nice_pkg::word_t    req_inst,
   input  nice_pkg::word_t    req_rs1,
   // response handed back
   input  logic               rsp_done,
   // towards sequencer and response side
   output logic               op_start,
   output nice_pkg::nice_op_t op,
   output nice_pkg::word_t    base_addr,
   output logic               illegal,
   output logic               busy,
   output logic               mem_busy
);
   import nice_pkg::*;

   logic [6:0] opcode;
   logic [2:0] func3;
   logic [6:0] func7;
   logic       is_lbuf;
   logic       is_sbuf;
   logic       is_rowsum;
   logic       is_legal;
   logic       req_hsk;
   logic       busy_r;
   logic       ill_r;
   nice_op_t   op_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////////////////////

   // R type fields
   assign opcode = req_inst[6:0];
   assign func3  = req_inst[14:12];
   assign func7  = req_inst[31:25];

   assign is_lbuf   = (opcode == OPCODE_CUSTOM3) & (func3 == F3_LBUF) & (func7 == F7_LBUF);
   assign is_sbuf   = (opcode == OPCODE_CUSTOM3) & (func3 == F3_SBUF) & (func7 == F7_SBUF);
   assign is_rowsum = (opcode == OPCODE_CUSTOM3) & (func3 == F3_ROWSUM)
                      & (func7 == F7_ROWSUM);
   assign is_legal  = is_lbuf | is_sbuf | is_rowsum;

   always_comb begin
      if (is_rowsum) begin
         op_nxt = op_rowsum;
      end else if (is_sbuf) begin
         op_nxt = op_sbuf;
      end else begin
         op_nxt = op_lbuf;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // acceptance
   ////////////////////////////////////////////////////////////////////////////

   // idle only, memory port not consulted
   assign req_ready = ~busy_r;
   assign req_hsk   = req_valid & req_ready;

   // pulses in the transfer cycle
   assign op_start = req_hsk & is_legal;
   assign illegal  = req_hsk & ~is_legal;

   // busy from transfer until the response leaves
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         busy_r <= 1'b0;
         ill_r  <= 1'b0;
      end else if (req_hsk) begin
         busy_r <= 1'b1;
         ill_r  <= ~is_legal;
      end else if (rsp_done) begin
         busy_r <= 1'b0;
         ill_r  <= 1'b0;
      end
   end

   // operation kept for the whole instruction
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         op <= op_lbuf;
      end else if (op_start) begin
         op <= op_nxt;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (op_start) begin
         base_addr <= req_rs1;
      end
   end

   assign busy = busy_r;
   // illegal ones never touch memory
   assign mem_busy = busy_r & ~ill_r;

endmodule

//--- hdl/nice_lsu_seq.sv
`timescale 1ns/1ps

module nice_lsu_seq (
   input  logic                  nice_clk,
   input  logic                  rst,
   // from the decoder
   input  logic                  op_start,
   input  nice_pkg::nice_op_t    op,
   input  nice_pkg::word_t       base_addr,
   // memory command
   output logic                  icb_cmd_valid,
   input  logic                  icb_cmd_ready,
   output nice_pkg::word_t       icb_cmd_addr,
   output logic                  icb_cmd_read,
   output nice_pkg::word_t       icb_cmd_wdata,
   output logic [1:0]            icb_cmd_size,
   // memory response
   input  logic                  icb_rsp_valid,
   output logic                  icb_rsp_ready,
   input  nice_pkg::word_t       icb_rsp_rdata,
   input  logic                  icb_rsp_err,
   // row buffer port
   output logic                  buf_wr,
   output logic                  buf_acc,
   output nice_pkg::rowbuf_idx_t buf_idx,
   output nice_pkg::word_t       buf_wdata,
   input  nice_pkg::word_t       buf_rdata,
   // completion
   output logic                  op_done,
   output logic                  op_err
);
   import nice_pkg::*;

   logic        run_r;
   rowbuf_idx_t cmd_cnt_r;
   rowbuf_idx_t rsp_cnt_r;
   word_t       addr_r;
   logic        err_r;
   logic        is_store;
   logic        cmd_left;
   logic        cmd_hsk;
   logic        rsp_hsk;
   logic        rsp_last;

   assign is_store = (op == op_sbuf);

   ////////////////////////////////////////////////////////////////////////////
   // command side
   ////////////////////////////////////////////////////////////////////////////

   // commands issued so far, runs ahead of responses
   assign cmd_left = (cmd_cnt_r != rowbuf_idx_t'(COL_NUM));

   assign icb_cmd_valid = run_r & cmd_left;
   assign cmd_hsk       = icb_cmd_valid & icb_cmd_ready;

   // first word straight from rs1
   assign icb_cmd_addr  = (cmd_cnt_r == '0) ? base_addr : addr_r;
   assign icb_cmd_read  = ~is_store;
   assign icb_cmd_wdata = is_store ? buf_rdata : '0;
   assign icb_cmd_size  = ICB_SIZE_WORD;

   always_ff @(posedge nice_clk) begin
      if (rst) begin
         cmd_cnt_r <= '0;
      end else if (op_done) begin
         cmd_cnt_r <= '0;
      end else if (cmd_hsk) begin
         cmd_cnt_r <= cmd_cnt_r + 1'b1;
      end
   end

   // next word address
   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) begin
         addr_r <= icb_cmd_addr + word_t'(WORD_BYTES);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // response side
   ////////////////////////////////////////////////////////////////////////////

   // always sink responses
   assign icb_rsp_ready = 1'b1;
   assign rsp_hsk       = run_r & icb_rsp_valid & icb_rsp_ready;
   assign rsp_last      = (rsp_cnt_r == rowbuf_idx_t'(COL_NUM - 1));

   always_ff @(posedge nice_clk) begin
      if (rst) begin
         rsp_cnt_r <= '0;
      end else if (op_done) begin
         rsp_cnt_r <= '0;
      end else if (rsp_hsk) begin
         rsp_cnt_r <= rsp_cnt_r + 1'b1;
      end
   end

   // sticky bus error over the instruction
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         err_r <= 1'b0;
      end else if (op_done) begin
         err_r <= 1'b0;
      end else if (rsp_hsk & icb_rsp_err) begin
         err_r <= 1'b1;
      end
   end

   // active from op_start to the last response
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         run_r <= 1'b0;
      end else if (op_start) begin
         run_r <= 1'b1;
      end else if (op_done) begin
         run_r <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // row buffer and completion
   ////////////////////////////////////////////////////////////////////////////

   // store reads by command, loads write by response
   assign buf_idx   = is_store ? cmd_cnt_r : rsp_cnt_r;
   assign buf_wdata = icb_rsp_rdata;
   assign buf_wr    = rsp_hsk & (op == op_lbuf);
   assign buf_acc   = rsp_hsk & (op == op_rowsum);

   assign op_done = rsp_hsk & rsp_last;
   // include the error of the last beat
   assign op_err  = err_r | (rsp_hsk & icb_rsp_err);

endmodule

//--- hdl/nice_rowbuf.sv
`timescale 1ns/1ps

module nice_rowbuf (
   input  logic                  nice_clk,
   input  logic                  rst,
   input  logic                  op_start,
   // write and accumulate port
   input  logic                  buf_wr,
   input  logic                  buf_acc,
   input  nice_pkg::rowbuf_idx_t buf_idx,
   input  nice_pkg::word_t       buf_wdata,
   // read side
   output nice_pkg::word_t       buf_rdata,
   output nice_pkg::word_t       row_sum
);
   import nice_pkg::*;

   word_t entry_r [ROWBUF_DP];
   word_t sum_r;
   word_t acc_data;
   word_t wr_data;
   logic  wr_any;

   ////////////////////////////////////////////////////////////////////////////
   // write data select
   ////////////////////////////////////////////////////////////////////////////

   // old entry plus incoming word
   assign acc_data = entry_r[buf_idx] + buf_wdata;

   // lbuf replaces, rowsum adds
   assign wr_data = buf_acc ? acc_data : buf_wdata;
   assign wr_any  = buf_wr | buf_acc;

   ////////////////////////////////////////////////////////////////////////////
   // entries
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < ROWBUF_DP; i++) begin : g_entry
      logic we;

      // one hot write enable
      assign we = wr_any & (buf_idx == rowbuf_idx_t'(i));

      always_ff @(posedge nice_clk) begin
         if (rst) begin
            entry_r[i] <= '0;
         end else if (we) begin
            entry_r[i] <= wr_data;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // row sum
   ////////////////////////////////////////////////////////////////////////////

   // restart on every new instruction
   always_ff @(posedge nice_clk) begin
      if (op_start) begin
         sum_r <= '0;
      end else if (buf_acc) begin
         sum_r <= sum_r + buf_wdata;
      end
   end

   // combinational read for the store path
   assign buf_rdata = entry_r[buf_idx];
   assign row_sum   = sum_r;

endmodule

//--- hdl/nice_rsp_ctrl.sv
`timescale 1ns/1ps

module nice_rsp_ctrl (
   input  logic               nice_clk,
   input  logic               rst,
   // completion sources
   input  logic               op_done,
   input  logic               op_err,
   input  logic               illegal,
   input  nice_pkg::nice_op_t op,
   input  nice_pkg::word_t    row_sum,
   // response to the core
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output nice_pkg::word_t    rsp_rdat,
   output logic               rsp_err,
   output logic               rsp_done
);
   import nice_pkg::*;

   logic valid_r;
   logic err_r;
   logic sum_sel_r;
   logic rsp_load;

   // either a finished memory op or a rejected instruction
   assign rsp_load = op_done | illegal;

   assign rsp_done = valid_r & rsp_ready;

   // held until the core takes it
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         valid_r   <= 1'b0;
         err_r     <= 1'b0;
         sum_sel_r <= 1'b0;
      end else if (rsp_load) begin
         valid_r   <= 1'b1;
         err_r     <= op_err | illegal;
         sum_sel_r <= op_done & (op == op_rowsum);
      end else if (rsp_done) begin
         valid_r <= 1'b0;
      end
   end

   assign rsp_valid = valid_r;
   assign rsp_err   = err_r;
   // sum register stays frozen until the next op_start
   assign rsp_rdat  = sum_sel_r ? row_sum : '0;

endmodule

//--- hdl/nice_core.sv
`timescale 1ns/1ps

module nice_core (
   input  logic            nice_clk,
   input  logic            rst,
   output logic            nice_active,
   output logic            nice_mem_holdup,
   // request
   input  logic            nice_req_valid,
   output logic            nice_req_ready,
   input  nice_pkg::word_t nice_req_inst,
   input  nice_pkg::word_t nice_req_rs1,
   input  nice_pkg::word_t nice_req_rs2,
   // response
   output logic            nice_rsp_valid,
   input  logic            nice_rsp_ready,
   output nice_pkg::word_t nice_rsp_rdat,
   output logic            nice_rsp_err,
   // memory command
   output logic            nice_icb_cmd_valid,
   input  logic            nice_icb_cmd_ready,
   output nice_pkg::word_t nice_icb_cmd_addr,
   output logic            nice_icb_cmd_read,
   output nice_pkg::word_t nice_icb_cmd_wdata,
   output logic [1:0]      nice_icb_cmd_size,
   // memory response
   input  logic            nice_icb_rsp_valid,
   output logic            nice_icb_rsp_ready,
   input  nice_pkg::word_t nice_icb_rsp_rdata,
   input  logic            nice_icb_rsp_err
);
   import nice_pkg::*;

   logic        op_start;
   nice_op_t    op;
   word_t       base_addr;
   logic        illegal;
   logic        busy;
   logic        mem_busy;
   logic        rsp_done;
   logic        buf_wr;
   logic        buf_acc;
   rowbuf_idx_t buf_idx;
   word_t       buf_wdata;
   word_t       buf_rdata;
   word_t       row_sum;
   logic        op_done;
   logic        op_err;

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////

   // rs2 has no use in these instructions
   nice_req_decode u_decode (
      .nice_clk  (nice_clk),
      .rst       (rst),
      .req_valid (nice_req_valid),
      .req_ready (nice_req_ready),
      .req_inst  (nice_req_inst),
      .req_rs1   (nice_req_rs1),
      .rsp_done  (rsp_done),
      .op_start  (op_start),
      .op        (op),
      .base_addr (base_addr),
      .illegal   (illegal),
      .busy      (busy),
      .mem_busy  (mem_busy)
   );

   ////////////////////////////////////////////////////////////////////////////
   // processing
   ////////////////////////////////////////////////////////////////////////////

   nice_rowbuf u_rowbuf (
      .nice_clk  (nice_clk),
      .rst       (rst),
      .op_start  (op_start),
      .buf_wr    (buf_wr),
      .buf_acc   (buf_acc),
      .buf_idx   (buf_idx),
      .buf_wdata (buf_wdata),
      .buf_rdata (buf_rdata),
      .row_sum   (row_sum)
   );

   ////////////////////////////////////////////////////////////////////////////
   // output side
   ////////////////////////////////////////////////////////////////////////////

   nice_lsu_seq u_lsu_seq (
      .nice_clk      (nice_clk),
      .rst           (rst),
      .op_start      (op_start),
      .op            (op),
      .base_addr     (base_addr),
      .icb_cmd_valid (nice_icb_cmd_valid),
      .icb_cmd_ready (nice_icb_cmd_ready),
      .icb_cmd_addr  (nice_icb_cmd_addr),
      .icb_cmd_read  (nice_icb_cmd_read),
      .icb_cmd_wdata (nice_icb_cmd_wdata),
      .icb_cmd_size  (nice_icb_cmd_size),
      .icb_rsp_valid (nice_icb_rsp_valid),
      .icb_rsp_ready (nice_icb_rsp_ready),
      .icb_rsp_rdata (nice_icb_rsp_rdata),
      .icb_rsp_err   (nice_icb_rsp_err),
      .buf_wr        (buf_wr),
      .buf_acc       (buf_acc),
      .buf_idx       (buf_idx),
      .buf_wdata     (buf_wdata),
      .buf_rdata     (buf_rdata),
      .op_done       (op_done),
      .op_err        (op_err)
   );

   nice_rsp_ctrl u_rsp_ctrl (
      .nice_clk  (nice_clk),
      .rst       (rst),
      .op_done   (op_done),
      .op_err    (op_err),
      .illegal   (illegal),
      .op        (op),
      .row_sum   (row_sum),
      .rsp_valid (nice_rsp_valid),
      .rsp_ready (nice_rsp_ready),
      .rsp_rdat  (nice_rsp_rdat),
      .rsp_err   (nice_rsp_err),
      .rsp_done  (rsp_done)
   );

   // clock request to the core
   assign nice_active     = busy | nice_req_valid;
   assign nice_mem_holdup = mem_busy;

endmodule

//--- verif/tb_nice_mem.sv
`timescale 1ns/1ps

module tb_nice_mem (
   input  logic            clk,
   input  logic            rst,
   // command side
   input  logic            cmd_valid,
   output logic            cmd_ready,
   input  nice_pkg::word_t cmd_addr,
   input  logic            cmd_read,
   input  nice_pkg::word_t cmd_wdata,
   // response side
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output nice_pkg::word_t rsp_rdata,
   output logic            rsp_err
);
   import nice_pkg::*;

   // bus error region starts here
   localparam word_t ERR_BASE = 32'h0000_f000;
   localparam word_t FILL_KEY = 32'h5a5a_0000;

   // written words, everything else reads as the fill pattern
   word_t store [word_t];

   // responses in flight, oldest first
   word_t q_data [$];
   logic  q_err [$];
   int    q_due [$];
   int    cyc;

   logic  cmd_ready_r = 1'b0;
   logic  rsp_valid_r = 1'b0;
   word_t rsp_rdata_r = '0;
   logic  rsp_err_r = 1'b0;

   function automatic word_t read_word(input word_t addr);
      if (store.exists(addr)) begin
         return store[addr];
      end
      return addr ^ FILL_KEY;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // transfers seen at the rising edge
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      int lat;
      int due;
      if (rst) begin
         q_data.delete();
         q_err.delete();
         q_due.delete();
         cyc = 0;
      end else begin
         cyc++;
         // head response taken by the DUT
         if (rsp_valid_r && rsp_ready) begin
            void'(q_data.pop_front());
            void'(q_err.pop_front());
            void'(q_due.pop_front());
         end
         if (cmd_valid && cmd_ready_r) begin
            // 0 to 3 extra cycles, never overtaking an older one
            lat = int'($urandom % 4);
            due = cyc + lat;
            if (q_due.size() > 0 && due < q_due[$]) begin
               due = q_due[$];
            end
            q_data.push_back(read_word(cmd_addr));
            q_err.push_back(cmd_addr >= ERR_BASE);
            q_due.push_back(due);
            // error region keeps its fill pattern
            if (!cmd_read && cmd_addr < ERR_BASE) begin
               store[cmd_addr] = cmd_wdata;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs change on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rst) begin
         cmd_ready_r = 1'b0;
         rsp_valid_r = 1'b0;
         rsp_rdata_r = '0;
         rsp_err_r   = 1'b0;
      end else begin
         // stall about one cycle in four
         cmd_ready_r = (($urandom % 4) != 0);
         if (q_due.size() > 0 && q_due[0] <= cyc) begin
            rsp_valid_r = 1'b1;
            rsp_rdata_r = q_data[0];
            rsp_err_r   = q_err[0];
         end else begin
            rsp_valid_r = 1'b0;
            rsp_rdata_r = '0;
            rsp_err_r   = 1'b0;
         end
      end
   end

   assign cmd_ready = cmd_ready_r;
   assign rsp_valid = rsp_valid_r;
   assign rsp_rdata = rsp_rdata_r;
   assign rsp_err   = rsp_err_r;

endmodule

//--- verif/tb_nice_core.sv
`timescale 1ns/1ps

module tb_nice_core;
   import nice_pkg::*;

   localparam int      NUM_TESTS = 10;
   localparam int      TIMEOUT_CYC = NUM_TESTS * 200 + 100;
   localparam word_t   ERR_BASE = 32'h0000_f000;
   localparam word_t   FILL_KEY = 32'h5a5a_0000;
   localparam bit [31:0] SEED = 32'hb478_b62a;

   // one instruction with its expected outcome
   typedef struct packed {
      nice_op_t                op;
      logic                    legal;
      word_t                   inst;
      word_t                   rs1;
      int                      hold;
      word_t                   rdat;
      logic                    err;
      word_t [COL_NUM-1:0]     wr;
   } entry_t;

   logic        clk = 1'b0;
   logic        rst;
   logic        nice_active;
   logic        nice_mem_holdup;
   logic        nice_req_valid;
   logic        nice_req_ready;
   word_t       nice_req_inst;
   word_t       nice_req_rs1;
   word_t       nice_req_rs2;
   logic        nice_rsp_valid;
   logic        nice_rsp_ready;
   word_t       nice_rsp_rdat;
   logic        nice_rsp_err;
   logic        nice_icb_cmd_valid;
   logic        nice_icb_cmd_ready;
   word_t       nice_icb_cmd_addr;
   logic        nice_icb_cmd_read;
   word_t       nice_icb_cmd_wdata;
   logic [1:0]  nice_icb_cmd_size;
   logic        nice_icb_rsp_valid;
   logic        nice_icb_rsp_ready;
   word_t       nice_icb_rsp_rdata;
   logic        nice_icb_rsp_err;

   entry_t      tbl [NUM_TESTS];
   word_t       exp_mem [word_t];
   word_t       exp_rb [ROWBUF_DP];
   // command transfers seen for the running instruction
   word_t       mon_addr [$];
   word_t       mon_wdata [$];
   logic        mon_read [$];
   logic        stall_seen;
   word_t       held_addr;
   word_t       held_wdata;
   logic        held_read;
   int          cycles;

   always #50 clk = ~clk;

   nice_core dut (
      .nice_clk           (clk),
      .rst                (rst),
      .nice_active        (nice_active),
      .nice_mem_holdup    (nice_mem_holdup),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_req_rs2       (nice_req_rs2),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_cmd_size  (nice_icb_cmd_size),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_ready (nice_icb_rsp_ready),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err)
   );

   tb_nice_mem u_mem (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (nice_icb_cmd_valid),
      .cmd_ready (nice_icb_cmd_ready),
      .cmd_addr  (nice_icb_cmd_addr),
      .cmd_read  (nice_icb_cmd_read),
      .cmd_wdata (nice_icb_cmd_wdata),
      .rsp_valid (nice_icb_rsp_valid),
      .rsp_ready (nice_icb_rsp_ready),
      .rsp_rdata (nice_icb_rsp_rdata),
      .rsp_err   (nice_icb_rsp_err)
   );

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input bit got, input bit exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // hard limit on the whole run
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYC) begin
         $display("run timed out after %0d cycles", cycles);
         abort_run();
      end
   end

   // command bus monitor and stability under stall
   always @(posedge clk) begin
      if (!rst) begin
         // memory responses always sunk
         check_flag("nice_icb_rsp_ready", nice_icb_rsp_ready, 1'b1);
         if (stall_seen) begin
            check_flag("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b1);
            check_word("nice_icb_cmd_addr", nice_icb_cmd_addr, held_addr);
            check_word("nice_icb_cmd_wdata", nice_icb_cmd_wdata, held_wdata);
            check_flag("nice_icb_cmd_read", nice_icb_cmd_read, held_read);
         end
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            check_word("nice_icb_cmd_size", word_t'(nice_icb_cmd_size),
                       word_t'(ICB_SIZE_WORD));
            mon_addr.push_back(nice_icb_cmd_addr);
            mon_wdata.push_back(nice_icb_cmd_wdata);
            mon_read.push_back(nice_icb_cmd_read);
         end
         stall_seen = nice_icb_cmd_valid && !nice_icb_cmd_ready;
         held_addr  = nice_icb_cmd_addr;
         held_wdata = nice_icb_cmd_wdata;
         held_read  = nice_icb_cmd_read;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // table and expected values
   ////////////////////////////////////////////////////////////////////////////

   // R type with rd x3, rs1 x1 and rs2 x2
   function automatic word_t make_inst(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [6:0] opc);
      return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
   endfunction

   function automatic word_t mem_word(input word_t addr);
      if (exp_mem.exists(addr)) begin
         return exp_mem[addr];
      end
      return addr ^ FILL_KEY;
   endfunction

   task automatic set_stim(input int i, input nice_op_t op, input logic legal,
                           input word_t inst, input word_t rs1, input int hold);
      tbl[i]       = '0;
      tbl[i].op    = op;
      tbl[i].legal = legal;
      tbl[i].inst  = inst;
      tbl[i].rs1   = rs1;
      tbl[i].hold  = hold;
   endtask

   task automatic build_table();
      set_stim(0, op_lbuf, 1'b1, make_inst(F7_LBUF, F3_LBUF, OPCODE_CUSTOM3), 32'h100, 0);
      set_stim(1, op_sbuf, 1'b1, make_inst(F7_SBUF, F3_SBUF, OPCODE_CUSTOM3), 32'h200, 1);
      set_stim(2, op_rowsum, 1'b1, make_inst(F7_ROWSUM, F3_ROWSUM, OPCODE_CUSTOM3),
               32'h300, 2);
      set_stim(3, op_sbuf, 1'b1, make_inst(F7_SBUF, F3_SBUF, OPCODE_CUSTOM3), 32'h400, 0);
      // plain OP opcode with lbuf func codes
      set_stim(4, op_lbuf, 1'b0, make_inst(F7_LBUF, F3_LBUF, 7'h33), 32'h100, 0);
      // custom-3 with an unknown func7
      set_stim(5, op_lbuf, 1'b0, make_inst(7'h05, F3_LBUF, OPCODE_CUSTOM3), 32'h100, 3);
      set_stim(6, op_lbuf, 1'b1, make_inst(F7_LBUF, F3_LBUF, OPCODE_CUSTOM3), 32'hf000, 0);
      set_stim(7, op_rowsum, 1'b1, make_inst(F7_ROWSUM, F3_ROWSUM, OPCODE_CUSTOM3),
               32'h200, 3);
      // crosses into the error region
      set_stim(8, op_sbuf, 1'b1, make_inst(F7_SBUF, F3_SBUF, OPCODE_CUSTOM3), 32'heffc, 0);
      set_stim(9, op_rowsum, 1'b1, make_inst(F7_ROWSUM, F3_ROWSUM, OPCODE_CUSTOM3),
               32'h400, 5);
   endtask

   task automatic compute_expected();
      word_t a;
      word_t w;
      for (int r = 0; r < ROWBUF_DP; r++) begin
         exp_rb[r] = '0;
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
         tbl[i].rdat = '0;
         tbl[i].err  = !tbl[i].legal;
         for (int k = 0; k < COL_NUM && tbl[i].legal; k++) begin
            a = tbl[i].rs1 + k * WORD_BYTES;
            w = mem_word(a);
            if (a >= ERR_BASE) begin
               tbl[i].err = 1'b1;
            end
            case (tbl[i].op)
               op_lbuf: exp_rb[k] = w;
               op_sbuf: begin
                  tbl[i].wr[k] = exp_rb[k];
                  if (a < ERR_BASE) begin
                     exp_mem[a] = exp_rb[k];
                  end
               end
               default: begin
                  exp_rb[k]    = exp_rb[k] + w;
                  tbl[i].rdat  = tbl[i].rdat + w;
               end
            endcase
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one instruction through the DUT
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_entry(input int i);
      word_t got_rdat;
      logic  got_err;
      int    waited;
      int    n_cmd;
      @(negedge clk);
      mon_addr.delete();
      mon_wdata.delete();
      mon_read.delete();
      nice_req_valid = 1'b1;
      nice_req_inst  = tbl[i].inst;
      nice_req_rs1   = tbl[i].rs1;
      // rs2 is don't care
      nice_req_rs2   = $urandom;
      @(posedge clk);
      while (!nice_req_ready) begin
         @(posedge clk);
      end
      @(negedge clk);
      nice_req_valid = 1'b0;
      // core keeps rsp_ready low until valid is seen
      @(posedge clk);
      waited = 1;
      while (!nice_rsp_valid) begin
         @(posedge clk);
         waited++;
      end
      if (!tbl[i].legal) begin
         check_word("illegal response latency", word_t'(waited), 32'd1);
      end
      // busy until the response leaves, memory held only by legal ones
      check_flag("nice_active", nice_active, 1'b1);
      check_flag("nice_mem_holdup", nice_mem_holdup, tbl[i].legal);
      got_rdat = nice_rsp_rdat;
      got_err  = nice_rsp_err;
      // back-pressure from the core
      repeat (tbl[i].hold) begin
         @(posedge clk);
         check_flag("nice_rsp_valid", nice_rsp_valid, 1'b1);
         check_word("nice_rsp_rdat", nice_rsp_rdat, got_rdat);
         check_flag("nice_rsp_err", nice_rsp_err, got_err);
         check_flag("nice_req_ready", nice_req_ready, 1'b0);
      end
      @(negedge clk);
      nice_rsp_ready = 1'b1;
      @(posedge clk);
      check_flag("nice_rsp_valid", nice_rsp_valid, 1'b1);
      @(negedge clk);
      nice_rsp_ready = 1'b0;
      // back to idle after the response transfer
      check_flag("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check_flag("nice_req_ready", nice_req_ready, 1'b1);
      check_flag("nice_active", nice_active, 1'b0);
      check_flag("nice_mem_holdup", nice_mem_holdup, 1'b0);
      check_word("nice_rsp_rdat", got_rdat, tbl[i].rdat);
      check_flag("nice_rsp_err", got_err, tbl[i].err);
      // illegal ones never reach memory
      n_cmd = tbl[i].legal ? COL_NUM : 0;
      check_word("nice_icb_cmd transfers", word_t'(mon_addr.size()), word_t'(n_cmd));
      for (int k = 0; k < n_cmd; k++) begin
         check_word("nice_icb_cmd_addr", mon_addr[k], tbl[i].rs1 + k * WORD_BYTES);
         check_flag("nice_icb_cmd_read", mon_read[k], tbl[i].op != op_sbuf);
         if (tbl[i].op == op_sbuf) begin
            check_word("nice_icb_cmd_wdata", mon_wdata[k], tbl[i].wr[k]);
         end
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rst            = 1'b1;
      nice_req_valid = 1'b0;
      nice_req_inst  = '0;
      nice_req_rs1   = '0;
      nice_req_rs2   = '0;
      nice_rsp_ready = 1'b0;
      stall_seen     = 1'b0;
      cycles         = 0;
      build_table();
      compute_expected();
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_entry(i);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

//--- sim.f
hdl/nice_pkg.sv
hdl/nice_req_decode.sv
hdl/nice_lsu_seq.sv
hdl/nice_rowbuf.sv
hdl/nice_rsp_ctrl.sv
hdl/nice_core.sv
verif/tb_nice_mem.sv
verif/tb_nice_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_nice_core \
   --Mdir obj_dir -o tb_nice_core

# the exit status of the pipe is the one of tee, the log decides
./obj_dir/tb_nice_core | tee sim.log

if grep -qx "all tests passed" sim.log; then
   echo "simulation PASS"
   exit 0
else
   echo "simulation FAIL"
   exit 1
fi
